// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/inst_fetch.sv
      - verilog/reg_file.sv
      - verilog/id_decode.sv
      - verilog/id_ex_buffer.sv
      - verilog/exec_retire.sv
      - verilog/mips_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/mips_core_tb.sv

// ==== mips_core.f ====
+incdir+verilog
verilog/mips_pkg.sv
verilog/inst_fetch.sv
verilog/reg_file.sv
verilog/id_decode.sv
verilog/id_ex_buffer.sv
verilog/exec_retire.sv
verilog/mips_core.sv
tests/mips_core_tb.sv

// ==== tests/mips_core_tb.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module mips_core_tb;

	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_SLTI    = 6'b001010;
	localparam logic [5:0] OPC_SLTIU   = 6'b001011;
	localparam logic [5:0] OPC_ANDI    = 6'b001100;
	localparam logic [5:0] OPC_ORI     = 6'b001101;
	localparam logic [5:0] OPC_XORI    = 6'b001110;
	localparam logic [5:0] OPC_LUI     = 6'b001111;

	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_MOVZ = 6'b001010;
	localparam logic [5:0] FN_MOVN = 6'b001011;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	logic              clk_i;
	logic              rst_n_i;
	logic              inst_valid_i;
	mips_pkg::word_t   inst_i;
	mips_pkg::retire_t retire_o;

	// reference state
	mips_pkg::word_t   model_regs [32];
	mips_pkg::word_t   model_pc;
	mips_pkg::retire_t exp_q [$];
	string             name_q [$];
	mips_pkg::word_t   sweep_q [$];
	integer            seed;

	mips_core dut_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.retire_o     (retire_o)
	);

	always #50 clk_i = ~clk_i;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_retire(input string name, input mips_pkg::retire_t exp,
		input mips_pkg::retire_t act);
		if (act !== exp) begin
			report_failure($sformatf(
				"mismatch in %s: expected pc=%h we=%b rd=%0d data=%h, actual pc=%h we=%b rd=%0d data=%h",
				name, exp.pc, exp.wr.we, exp.wr.waddr, exp.wr.wdata,
				act.pc, act.wr.we, act.wr.waddr, act.wr.wdata));
		end
	endtask

	task automatic check_word(input string name, input mips_pkg::word_t exp,
		input mips_pkg::word_t act);
		if (act !== exp) begin
			report_failure($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	function automatic mips_pkg::word_t r_type(input logic [5:0] fn,
		input mips_pkg::reg_addr_t rd, rs, rt, input logic [4:0] sh);
		return {OPC_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic mips_pkg::word_t i_type(input logic [5:0] opc,
		input mips_pkg::reg_addr_t rt, rs, input mips_pkg::half_word_t imm);
		return {opc, rs, rt, imm};
	endfunction

	// expected write-back of one instruction, updates model_regs and model_pc
	function automatic mips_pkg::retire_t model_exec(input mips_pkg::word_t inst);
		mips_pkg::retire_t res;
		mips_pkg::word_t   a;
		mips_pkg::word_t   b;
		mips_pkg::word_t   imm_s;
		mips_pkg::word_t   imm_z;
		res       = '0;
		res.pc    = model_pc;
		model_pc  = model_pc + `MIPS_PC_STEP;
		a         = model_regs[inst[25:21]];
		b         = model_regs[inst[20:16]];
		imm_s     = {{16{inst[15]}}, inst[15:0]};
		imm_z     = {16'h0000, inst[15:0]};
		res.wr.we = 1'b1;
		res.wr.waddr = inst[20:16];
		case (inst[31:26])
			OPC_ADDIU: res.wr.wdata = a + imm_s;
			OPC_SLTI:  res.wr.wdata = {31'd0, $signed(a) < $signed(imm_s)};
			OPC_SLTIU: res.wr.wdata = {31'd0, a < imm_s};
			OPC_ANDI:  res.wr.wdata = a & imm_z;
			OPC_ORI:   res.wr.wdata = a | imm_z;
			OPC_XORI:  res.wr.wdata = a ^ imm_z;
			OPC_LUI:   res.wr.wdata = {inst[15:0], 16'h0000};
			OPC_SPECIAL: begin
				res.wr.waddr = inst[15:11];
				case (inst[5:0])
					FN_SLL:  res.wr.wdata = b << inst[10:6];
					FN_SRL:  res.wr.wdata = b >> inst[10:6];
					FN_ADDU: res.wr.wdata = a + b;
					FN_SUBU: res.wr.wdata = a - b;
					FN_AND:  res.wr.wdata = a & b;
					FN_OR:   res.wr.wdata = a | b;
					FN_XOR:  res.wr.wdata = a ^ b;
					FN_NOR:  res.wr.wdata = ~(a | b);
					FN_SLT:  res.wr.wdata = {31'd0, $signed(a) < $signed(b)};
					FN_SLTU: res.wr.wdata = {31'd0, a < b};
					FN_MOVN: begin
						res.wr.we    = (b != 32'd0);
						res.wr.wdata = a;
					end
					FN_MOVZ: begin
						res.wr.we    = (b == 32'd0);
						res.wr.wdata = a;
					end
					default: res.wr.we = 1'b0;
				endcase
			end
			default: res.wr.we = 1'b0;
		endcase
		if (!res.wr.we) begin
			res.wr = '0;
		end else if (res.wr.waddr != `MIPS_REG_ZERO) begin
			model_regs[res.wr.waddr] = res.wr.wdata;
		end
		return res;
	endfunction

	function automatic logic [5:0] reg_funct(input int idx);
		case (idx)
			0:       return FN_ADDU;
			1:       return FN_SUBU;
			2:       return FN_AND;
			3:       return FN_OR;
			4:       return FN_XOR;
			5:       return FN_NOR;
			6:       return FN_SLT;
			7:       return FN_SLTU;
			8:       return FN_SLL;
			default: return FN_SRL;
		endcase
	endfunction

	task automatic issue(input string name, input mips_pkg::word_t inst);
		mips_pkg::retire_t exp;
		@(negedge clk_i);
		inst_valid_i = 1'b1;
		inst_i       = inst;
		exp          = model_exec(inst);
		if (exp.wr.we) begin
			exp_q.push_back(exp);
			name_q.push_back(name);
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk_i);
			inst_valid_i = 1'b0;
		end
	endtask

	task automatic load_word(input string name, input mips_pkg::reg_addr_t rd,
		input mips_pkg::word_t value);
		issue(name, i_type(OPC_LUI, rd, 5'd0, value[31:16]));
		issue(name, i_type(OPC_ORI, rd, rd, value[15:0]));
	endtask

	// pre-edge values of retire_o are stable here
	always @(posedge clk_i) begin
		mips_pkg::retire_t exp;
		string             name;
		if (rst_n_i && retire_o.wr.we) begin
			if (exp_q.size() == 0) begin
				report_failure($sformatf("unexpected write-back from pc %h", retire_o.pc));
			end
			exp  = exp_q.pop_front();
			name = name_q.pop_front();
			check_retire(name, exp, retire_o);
			if (name == "reg_sweep") begin
				sweep_q.push_back(retire_o.wr.wdata);
			end
		end
	end

	initial begin
		mips_pkg::word_t a;
		int              timeout;
		int              pick;
		seed         = 49;
		clk_i        = 1'b0;
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		model_pc     = `MIPS_RESET_PC;
		for (int k = 0; k < 32; k++) begin
			model_regs[k] = `MIPS_ZERO_WORD;
		end
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;

		// immediate forms, negative and positive immediates
		issue("imm_ops", i_type(OPC_ADDIU, 5'd1, 5'd0, 16'h8001));
		issue("imm_ops", i_type(OPC_ADDIU, 5'd2, 5'd1, 16'h7fff));
		// results differ between sign and zero extension
		issue("imm_ops", i_type(OPC_SLTI, 5'd3, 5'd0, 16'h8000));
		issue("imm_ops", i_type(OPC_SLTIU, 5'd4, 5'd1, 16'hffff));
		issue("imm_ops", i_type(OPC_ANDI, 5'd5, 5'd1, 16'hf0f0));
		issue("imm_ops", i_type(OPC_ORI, 5'd6, 5'd0, 16'h8001));
		issue("imm_ops", i_type(OPC_XORI, 5'd7, 5'd6, 16'hffff));
		issue("imm_ops", i_type(OPC_LUI, 5'd8, 5'd3, 16'h8123));

		for (int j = 0; j < 10; j++) begin
			a = $random(seed);
			load_word("reg_ops", 5'd10, a);
			a = $random(seed);
			load_word("reg_ops", 5'd11, a);
			a = $random(seed);
			issue("reg_ops", r_type(reg_funct(j), 5'd12 + j[4:0], 5'd10, 5'd11, a[4:0]));
		end

		// newest value must win at distance 1, 2 and 3
		for (int d = 1; d <= 3; d++) begin
			issue("forwarding", i_type(OPC_ADDIU, 5'd20, 5'd0, 16'h0005));
			issue("forwarding", i_type(OPC_ADDIU, 5'd20, 5'd0, 16'h0006));
			issue("forwarding", i_type(OPC_ADDIU, 5'd20, 5'd20, 16'h0100));
			for (int f = 1; f < d; f++) begin
				issue("forwarding", i_type(OPC_ORI, 5'd23, 5'd0, 16'h00aa));
			end
			issue("forwarding", r_type(FN_ADDU, 5'd21, 5'd20, 5'd20, 5'd0));
			issue("forwarding", r_type(FN_SUBU, 5'd22, 5'd21, 5'd20, 5'd0));
		end

		issue("cond_move", i_type(OPC_ORI, 5'd24, 5'd0, 16'h1234));
		issue("cond_move", r_type(FN_ADDU, 5'd25, 5'd0, 5'd0, 5'd0));
		issue("cond_move", i_type(OPC_ORI, 5'd26, 5'd0, 16'h0001));
		issue("cond_move", r_type(FN_MOVN, 5'd27, 5'd24, 5'd26, 5'd0));
		issue("cond_move", r_type(FN_MOVN, 5'd28, 5'd24, 5'd25, 5'd0));
		issue("cond_move", r_type(FN_MOVZ, 5'd29, 5'd24, 5'd25, 5'd0));
		issue("cond_move", r_type(FN_MOVZ, 5'd30, 5'd24, 5'd26, 5'd0));
		// condition value arrives through the ex bypass
		issue("cond_move", i_type(OPC_ANDI, 5'd26, 5'd0, 16'h0000));
		issue("cond_move", r_type(FN_MOVN, 5'd27, 5'd25, 5'd26, 5'd0));
		issue("cond_move", r_type(FN_MOVZ, 5'd28, 5'd26, 5'd26, 5'd0));

		issue("reg_zero", i_type(OPC_ADDIU, 5'd0, 5'd0, 16'h0055));
		issue("reg_zero", r_type(FN_ADDU, 5'd9, 5'd0, 5'd0, 5'd0));
		issue("reg_zero", i_type(OPC_LUI, 5'd0, 5'd0, 16'hffff));
		issue("reg_zero", r_type(FN_OR, 5'd9, 5'd0, 5'd0, 5'd0));
		issue("invalid", 32'hfc00_0000);
		issue("invalid", 32'h0000_003f);
		issue("invalid", 32'h0800_0010);
		issue("invalid", i_type(OPC_ADDIU, 5'd9, 5'd0, 16'h0001));

		for (int n = 0; n < 40; n++) begin
			idle({$random(seed)} % 3);
			pick = {$random(seed)} % 4;
			a    = $random(seed);
			case (pick)
				0: issue("bubbles", i_type(OPC_ADDIU, 5'd1 + a[4:0] % 31, a[9:5], a[31:16]));
				1: issue("bubbles", i_type(OPC_ORI, 5'd1 + a[4:0] % 31, a[9:5], a[31:16]));
				2: issue("bubbles", r_type(FN_ADDU, 5'd1 + a[4:0] % 31, a[9:5], a[14:10], 5'd0));
				default: issue("bubbles", r_type(FN_XOR, a[4:0], a[9:5], a[14:10], 5'd0));
			endcase
		end

		for (int k = 0; k < 32; k++) begin
			issue("reg_sweep", r_type(FN_OR, k[4:0], k[4:0], 5'd0, 5'd0));
		end
		idle(1);

		timeout = 0;
		while (exp_q.size() != 0 && timeout < 20) begin
			@(posedge clk_i);
			timeout++;
		end
		if (exp_q.size() != 0) begin
			report_failure("timeout: write-backs still outstanding after 20 cycles");
		end else begin
			if (sweep_q.size() != 32) begin
				report_failure($sformatf("register sweep returned %0d values instead of 32",
					sweep_q.size()));
			end
			for (int k = 0; k < 32; k++) begin
				check_word($sformatf("reg_sweep r%0d", k), model_regs[k], sweep_q[k]);
			end
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ns

module mips_core (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              inst_valid_i,
	input  mips_pkg::word_t   inst_i,
	output mips_pkg::retire_t retire_o
);

	mips_pkg::if_id_t         if_id;
	mips_pkg::id_ex_t         id_data;
	mips_pkg::id_ex_t         ex_data;
	mips_pkg::reg_addr_t      reg_raddr1;
	mips_pkg::reg_addr_t      reg_raddr2;
	mips_pkg::word_t          reg1;
	mips_pkg::word_t          reg2;
	mips_pkg::reg_write_req_t ex_wr;
	mips_pkg::reg_write_req_t mem_wr;
	mips_pkg::reg_write_req_t wb_wr;

	inst_fetch inst_fetch_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.if_id_o      (if_id)
	);

	// write-back port doubles as the third forwarding path
	reg_file reg_file_i (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.raddr1_i (reg_raddr1),
		.raddr2_i (reg_raddr2),
		.wr_i     (wb_wr),
		.rdata1_o (reg1),
		.rdata2_o (reg2)
	);

	id_decode id_decode_i (
		.if_id_i      (if_id),
		.reg1_i       (reg1),
		.reg2_i       (reg2),
		.ex_wr_i      (ex_wr),
		.mem_wr_i     (mem_wr),
		.reg_raddr1_o (reg_raddr1),
		.reg_raddr2_o (reg_raddr2),
		.id_data_o    (id_data)
	);

	id_ex_buffer id_ex_buffer_i (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.id_data_i (id_data),
		.ex_data_o (ex_data)
	);

	exec_retire exec_retire_i (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.ex_data_i (ex_data),
		.ex_wr_o   (ex_wr),
		.mem_wr_o  (mem_wr),
		.wb_wr_o   (wb_wr),
		.retire_o  (retire_o)
	);

endmodule

// ==== verilog/exec_retire.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module exec_retire (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  mips_pkg::id_ex_t         ex_data_i,
	output mips_pkg::reg_write_req_t ex_wr_o,
	output mips_pkg::reg_write_req_t mem_wr_o,
	output mips_pkg::reg_write_req_t wb_wr_o,
	output mips_pkg::retire_t        retire_o
);

	mips_pkg::word_t   alu_result;
	mips_pkg::retire_t ex_mem_q;
	mips_pkg::retire_t mem_wb_q;

	// ALU, reg2 already holds the immediate for I-type
	always_comb begin
		case (ex_data_i.op)
			mips_pkg::OP_ADDU: alu_result = ex_data_i.reg1 + ex_data_i.reg2;
			mips_pkg::OP_SUBU: alu_result = ex_data_i.reg1 - ex_data_i.reg2;
			mips_pkg::OP_AND:  alu_result = ex_data_i.reg1 & ex_data_i.reg2;
			mips_pkg::OP_OR:   alu_result = ex_data_i.reg1 | ex_data_i.reg2;
			mips_pkg::OP_XOR:  alu_result = ex_data_i.reg1 ^ ex_data_i.reg2;
			mips_pkg::OP_NOR:  alu_result = ~(ex_data_i.reg1 | ex_data_i.reg2);
			mips_pkg::OP_SLT: begin
				alu_result = ($signed(ex_data_i.reg1) < $signed(ex_data_i.reg2)) ?
					32'd1 : `MIPS_ZERO_WORD;
			end
			mips_pkg::OP_SLTU: begin
				alu_result = (ex_data_i.reg1 < ex_data_i.reg2) ? 32'd1 : `MIPS_ZERO_WORD;
			end
			mips_pkg::OP_SLL:  alu_result = ex_data_i.reg2 << ex_data_i.shamt;
			mips_pkg::OP_SRL:  alu_result = ex_data_i.reg2 >> ex_data_i.shamt;
			mips_pkg::OP_LUI:  alu_result = ex_data_i.reg2 << 16;
			// condition was resolved in decode
			mips_pkg::OP_MOVN: alu_result = ex_data_i.reg1;
			mips_pkg::OP_MOVZ: alu_result = ex_data_i.reg1;
			default:           alu_result = `MIPS_ZERO_WORD;
		endcase
	end

	// bubbles arrive with we cleared
	assign ex_wr_o.we    = ex_data_i.wr.we;
	assign ex_wr_o.waddr = ex_data_i.wr.waddr;
	assign ex_wr_o.wdata = alu_result;

	// EX/MEM then MEM/WB, pc travels along for retire
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_mem_q <= '0;
			mem_wb_q <= '0;
		end else begin
			ex_mem_q.pc <= ex_data_i.pc;
			ex_mem_q.wr <= ex_wr_o;
			mem_wb_q    <= ex_mem_q;
		end
	end

	assign mem_wr_o = ex_mem_q.wr;
	assign wb_wr_o  = mem_wb_q.wr;
	assign retire_o = mem_wb_q;

endmodule

// ==== verilog/id_ex_buffer.sv ====
`timescale 1ns/1ns

module id_ex_buffer (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  mips_pkg::id_ex_t id_data_i,
	output mips_pkg::id_ex_t ex_data_o
);

	mips_pkg::id_ex_t next_data;
	mips_pkg::id_ex_t ex_data_q;

	// squash anything that must not reach execute
	always_comb begin
		if (!id_data_i.valid || id_data_i.op == mips_pkg::OP_INVALID) begin
			next_data = '0;
		end else begin
			next_data = id_data_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_data_q <= '0;
		end else begin
			ex_data_q <= next_data;
		end
	end

	assign ex_data_o = ex_data_q;

endmodule

// ==== verilog/id_decode.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module id_decode (
	input  mips_pkg::if_id_t         if_id_i,
	input  mips_pkg::word_t          reg1_i,
	input  mips_pkg::word_t          reg2_i,
	input  mips_pkg::reg_write_req_t ex_wr_i,
	input  mips_pkg::reg_write_req_t mem_wr_i,
	output mips_pkg::reg_addr_t      reg_raddr1_o,
	output mips_pkg::reg_addr_t      reg_raddr2_o,
	output mips_pkg::id_ex_t         id_data_o
);

	// instruction fields
	logic [5:0]           opcode;
	logic [5:0]           funct;
	mips_pkg::reg_addr_t  rs;
	mips_pkg::reg_addr_t  rt;
	mips_pkg::reg_addr_t  rd;
	mips_pkg::reg_addr_t  shamt;
	mips_pkg::half_word_t immediate;

	mips_pkg::word_t      imm_zero_ext;
	mips_pkg::word_t      imm_sign_ext;
	mips_pkg::word_t      safe_reg1;
	mips_pkg::word_t      safe_reg2;
	mips_pkg::word_t      reg2_sel;

	mips_pkg::oper_t      op_type_i;
	mips_pkg::oper_t      op_type_r;
	mips_pkg::oper_t      op;
	logic                 unsigned_imm;
	logic                 movn_not_taken;
	logic                 movz_not_taken;
	logic                 reg_we;
	mips_pkg::reg_addr_t  reg_waddr;

	assign opcode    = if_id_i.inst[31:26];
	assign rs        = if_id_i.inst[25:21];
	assign rt        = if_id_i.inst[20:16];
	assign rd        = if_id_i.inst[15:11];
	assign shamt     = if_id_i.inst[10:6];
	assign funct     = if_id_i.inst[5:0];
	assign immediate = if_id_i.inst[15:0];

	assign imm_zero_ext = {16'h0000, immediate};
	assign imm_sign_ext = {{16{immediate[15]}}, immediate};

	// I-type sub-decoder
	always_comb begin
		op_type_i    = mips_pkg::OP_INVALID;
		unsigned_imm = 1'b0;
		case (opcode)
			6'b001001: op_type_i = mips_pkg::OP_ADDU;
			6'b001010: op_type_i = mips_pkg::OP_SLT;
			6'b001011: op_type_i = mips_pkg::OP_SLTU;
			6'b001100: begin
				op_type_i    = mips_pkg::OP_AND;
				unsigned_imm = 1'b1;
			end
			6'b001101: begin
				op_type_i    = mips_pkg::OP_OR;
				unsigned_imm = 1'b1;
			end
			6'b001110: begin
				op_type_i    = mips_pkg::OP_XOR;
				unsigned_imm = 1'b1;
			end
			6'b001111: begin
				op_type_i    = mips_pkg::OP_LUI;
				unsigned_imm = 1'b1;
			end
			default: op_type_i = mips_pkg::OP_INVALID;
		endcase
	end

	// R-type sub-decoder, SPECIAL opcode only
	always_comb begin
		op_type_r = mips_pkg::OP_INVALID;
		if (opcode == 6'b000000) begin
			case (funct)
				6'b000000: op_type_r = mips_pkg::OP_SLL;
				6'b000010: op_type_r = mips_pkg::OP_SRL;
				6'b001010: op_type_r = mips_pkg::OP_MOVZ;
				6'b001011: op_type_r = mips_pkg::OP_MOVN;
				6'b100001: op_type_r = mips_pkg::OP_ADDU;
				6'b100011: op_type_r = mips_pkg::OP_SUBU;
				6'b100100: op_type_r = mips_pkg::OP_AND;
				6'b100101: op_type_r = mips_pkg::OP_OR;
				6'b100110: op_type_r = mips_pkg::OP_XOR;
				6'b100111: op_type_r = mips_pkg::OP_NOR;
				6'b101010: op_type_r = mips_pkg::OP_SLT;
				6'b101011: op_type_r = mips_pkg::OP_SLTU;
				default:   op_type_r = mips_pkg::OP_INVALID;
			endcase
		end
	end

	// read addresses depend on the format only, never on read data
	always_comb begin
		reg_raddr1_o = `MIPS_REG_ZERO;
		reg_raddr2_o = `MIPS_REG_ZERO;
		if (op_type_i != mips_pkg::OP_INVALID) begin
			reg_raddr1_o = rs;
		end else if (op_type_r != mips_pkg::OP_INVALID) begin
			reg_raddr1_o = rs;
			reg_raddr2_o = rt;
		end
	end

	// ex result is newer than mem, mem newer than the register file
	function automatic mips_pkg::word_t forward(input mips_pkg::reg_addr_t addr,
		input mips_pkg::word_t rf_data);
		if (addr == `MIPS_REG_ZERO) begin
			return `MIPS_ZERO_WORD;
		end else if (ex_wr_i.we && ex_wr_i.waddr == addr) begin
			return ex_wr_i.wdata;
		end else if (mem_wr_i.we && mem_wr_i.waddr == addr) begin
			return mem_wr_i.wdata;
		end
		return rf_data;
	endfunction

	always_comb begin
		safe_reg1 = forward(reg_raddr1_o, reg1_i);
		safe_reg2 = forward(reg_raddr2_o, reg2_i);
	end

	// conditional moves test the forwarded rt value
	assign movn_not_taken = op_type_r == mips_pkg::OP_MOVN && safe_reg2 == `MIPS_ZERO_WORD;
	assign movz_not_taken = op_type_r == mips_pkg::OP_MOVZ && safe_reg2 != `MIPS_ZERO_WORD;

	always_comb begin
		op        = mips_pkg::OP_INVALID;
		reg2_sel  = safe_reg2;
		reg_we    = 1'b0;
		reg_waddr = `MIPS_REG_ZERO;
		if (op_type_i != mips_pkg::OP_INVALID) begin
			op        = op_type_i;
			reg2_sel  = unsigned_imm ? imm_zero_ext : imm_sign_ext;
			reg_we    = 1'b1;
			reg_waddr = rt;
		end else if (op_type_r != mips_pkg::OP_INVALID) begin
			op        = op_type_r;
			reg_we    = ~(movn_not_taken | movz_not_taken);
			reg_waddr = rd;
		end
	end

	assign id_data_o.valid    = if_id_i.valid;
	assign id_data_o.op       = op;
	assign id_data_o.pc       = if_id_i.pc;
	assign id_data_o.reg1     = safe_reg1;
	assign id_data_o.reg2     = reg2_sel;
	assign id_data_o.shamt    = shamt;
	assign id_data_o.wr.we    = reg_we;
	assign id_data_o.wr.waddr = reg_waddr;
	assign id_data_o.wr.wdata = `MIPS_ZERO_WORD;

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module reg_file (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  mips_pkg::reg_addr_t      raddr1_i,
	input  mips_pkg::reg_addr_t      raddr2_i,
	input  mips_pkg::reg_write_req_t wr_i,
	output mips_pkg::word_t          rdata1_o,
	output mips_pkg::word_t          rdata2_o
);

	mips_pkg::word_t regs [32];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= `MIPS_ZERO_WORD;
			end
		end else if (wr_i.we && wr_i.waddr != `MIPS_REG_ZERO) begin
			regs[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// write-first: a same-cycle write wins over the stored value
	function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
		if (addr == `MIPS_REG_ZERO) begin
			return `MIPS_ZERO_WORD;
		end else if (wr_i.we && wr_i.waddr == addr) begin
			return wr_i.wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

// ==== verilog/inst_fetch.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module inst_fetch (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             inst_valid_i,
	input  mips_pkg::word_t  inst_i,
	output mips_pkg::if_id_t if_id_o
);

	mips_pkg::word_t  pc_q;
	mips_pkg::if_id_t if_id_q;

	// pc only moves on accepted instructions
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q    <= `MIPS_RESET_PC;
			if_id_q <= '0;
		end else if (inst_valid_i) begin
			if_id_q.valid <= 1'b1;
			if_id_q.pc    <= pc_q;
			if_id_q.inst  <= inst_i;
			pc_q          <= pc_q + `MIPS_PC_STEP;
		end else begin
			// bubble, payload left as is
			if_id_q.valid <= 1'b0;
		end
	end

	assign if_id_o = if_id_q;

endmodule

// ==== verilog/mips_pkg.sv ====
package mips_pkg;

	// basic data widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] half_word_t;

	// ALU operation selected by decode
	// immediate forms share the code of their register form
	typedef enum logic [4:0] {
		OP_INVALID,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_SLT,
		OP_SLTU,
		OP_SLL,
		OP_SRL,
		OP_LUI,
		OP_MOVN,
		OP_MOVZ
	} oper_t;

	// register write request, also used as a forwarding source
	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_write_req_t;

	// IF/ID pipeline register
	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t inst;
	} if_id_t;

	// ID/EX pipeline register
	// wr.wdata is filled in by execute
	typedef struct packed {
		logic           valid;
		oper_t          op;
		word_t          pc;
		word_t          reg1;
		word_t          reg2;
		reg_addr_t      shamt;
		reg_write_req_t wr;
	} id_ex_t;

	// one retired write-back
	typedef struct packed {
		word_t          pc;
		reg_write_req_t wr;
	} retire_t;

endpackage

// ==== verilog/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// byte distance between consecutive instructions
`define MIPS_PC_STEP 32'd4

// all-zero data word
`define MIPS_ZERO_WORD 32'h0000_0000

// hardwired zero register
`define MIPS_REG_ZERO 5'd0

`endif
